//--- rtl/alu_pkg.sv
/*
 * ALU shared definitions
 * Widths, dense opcode map and the result structs of the three units
 */

package alu_pkg;

	localparam int DATA_W      = 32;     // Datapath width
	localparam int OP_W        = 6;      // Opcode field width
	localparam int SHAMT_LIMIT = DATA_W; // Shift at or past this empties the word

	typedef logic signed [DATA_W-1:0] alu_word_t;

	// ***********************************************************************
	// Opcode map, dense from 0, codes past SRS are illegal
	// ***********************************************************************

	typedef enum logic [OP_W-1:0] {
		NOP, LOD,                           // Moves, b and a
		ADD, MLT, SGN,                      // Two operand arithmetic
		NEG, NEG_M, ABS, ABS_M, PST, PST_M, // Plain on b, _M on a
		AND, ORR, XOR, INV, INV_M,          // Bitwise
		LAN, LOR, LIN, LIN_M,               // Boolean, 1 or 0
		LES, GRE, EQU,                      // Signed compares
		SHL, SHR, SRS                       // Shifts of a by b
	} alu_op_e;

	localparam alu_op_e OP_LAST = SRS; // Highest legal code

	// ***********************************************************************
	// Registered unit results
	// ***********************************************************************

	typedef struct packed {
		alu_word_t nop;
		alu_word_t lod;
		alu_word_t add;
		alu_word_t mlt;   // Low half of product
		alu_word_t sgn;
		alu_word_t neg;
		alu_word_t neg_m;
		alu_word_t abs;
		alu_word_t abs_m;
		alu_word_t pst;
		alu_word_t pst_m;
	} arith_res_t;

	typedef struct packed {
		alu_word_t ann;   // and
		alu_word_t orr;   // or
		alu_word_t cor;   // xor
		alu_word_t inv;
		alu_word_t inv_m;
		alu_word_t lan;
		alu_word_t lor;
		alu_word_t lin;
		alu_word_t lin_m;
	} logic_res_t;

	typedef struct packed {
		alu_word_t les;
		alu_word_t gre;
		alu_word_t equ;
		alu_word_t shl;
		alu_word_t shr;
		alu_word_t srs;
	} cmp_shift_res_t;

	// Boolean flag widened to a data word
	function automatic alu_word_t to_word(input logic flag);
		return {{(DATA_W-1){1'b0}}, flag};
	endfunction

endpackage

//--- rtl/alu_issue_if.sv
/*
 * ALU issue bundle
 * One operation per cycle, opcode plus memory and accumulator operands
 */

`timescale 1ns/1ps

interface alu_issue_if;

	logic                valid; // Item present this cycle
	alu_pkg::alu_op_e    op;
	alu_pkg::alu_word_t  a;     // From memory
	alu_pkg::alu_word_t  b;     // From accumulator

	// Driven straight from the top level ports
	modport src (
		output valid, op, a, b
	);

	// Units and result selector only listen
	modport unit (
		input valid, op, a, b
	);

endinterface

//--- rtl/alu_arith.sv
/*
 * ALU arithmetic unit
 * Moves, add, multiply, sign copy and the single operand forms on a and b
 */

`timescale 1ns/1ps

module alu_arith (
	input  logic                  clk,
	alu_issue_if.unit             issue,
	output alu_pkg::arith_res_t   res
);

	// ***********************************************************************
	// Single operand helpers, shared by the plain and _M forms
	// ***********************************************************************

	// Magnitude, most negative value wraps to itself
	function automatic alu_pkg::alu_word_t abs_of(input alu_pkg::alu_word_t x);
		return x[alu_pkg::DATA_W-1] ? -x : x;
	endfunction

	// Clamp negatives to zero
	function automatic alu_pkg::alu_word_t pst_of(input alu_pkg::alu_word_t x);
		return x[alu_pkg::DATA_W-1] ? '0 : x;
	endfunction

	// b with the sign of a
	function automatic alu_pkg::alu_word_t sgn_of(
		input alu_pkg::alu_word_t src,
		input alu_pkg::alu_word_t val
	);
		logic same; // Sign bits agree
		same = (src[alu_pkg::DATA_W-1] == val[alu_pkg::DATA_W-1]);
		return same ? val : -val;
	endfunction

	// ***********************************************************************
	// Result register, every field updated each cycle
	// ***********************************************************************

	always_ff @(posedge clk) begin
		res.nop   <= issue.b;                  // Keep accumulator
		res.lod   <= issue.a;                  // Load from memory
		res.add   <= issue.a + issue.b;
		res.mlt   <= issue.a * issue.b;        // Truncated to the word
		res.sgn   <= sgn_of(issue.a, issue.b);

		// Plain forms act on b
		res.neg   <= -issue.b;
		res.abs   <= abs_of(issue.b);
		res.pst   <= pst_of(issue.b);

		// _M forms act on a
		res.neg_m <= -issue.a;
		res.abs_m <= abs_of(issue.a);
		res.pst_m <= pst_of(issue.a);
	end

endmodule

//--- rtl/alu_logic.sv
/*
 * ALU logic unit
 * Bitwise and, or, xor, not plus the 1/0 boolean tests against zero
 */

`timescale 1ns/1ps

module alu_logic (
	input  logic                  clk,
	alu_issue_if.unit             issue,
	output alu_pkg::logic_res_t   res
);

	logic a_nz; // a is nonzero
	logic b_nz; // b is nonzero

	// Zero tests shared by all four boolean ops
	assign a_nz = (issue.a != '0);
	assign b_nz = (issue.b != '0);

	// ***********************************************************************
	// Bitwise results
	// ***********************************************************************

	always_ff @(posedge clk) begin
		res.ann   <= issue.a & issue.b;
		res.orr   <= issue.a | issue.b;
		res.cor   <= issue.a ^ issue.b;
		res.inv   <= ~issue.b;   // Accumulator
		res.inv_m <= ~issue.a;   // Memory operand
	end

	// ***********************************************************************
	// Boolean results, always 1 or 0
	// ***********************************************************************

	always_ff @(posedge clk) begin
		res.lan   <= alu_pkg::to_word(a_nz && b_nz);
		res.lor   <= alu_pkg::to_word(a_nz || b_nz);

		// Logical not, true when the operand is zero
		res.lin   <= alu_pkg::to_word(!b_nz);
		res.lin_m <= alu_pkg::to_word(!a_nz);
	end

endmodule

//--- rtl/alu_cmp_shift.sv
/*
 * ALU compare and shift unit
 * Signed compares of a against b, shifts of a by the full value of b
 */

`timescale 1ns/1ps

module alu_cmp_shift (
	input  logic                    clk,
	alu_issue_if.unit               issue,
	output alu_pkg::cmp_shift_res_t res
);

	logic                                shift_out; // Amount empties the word
	logic [$clog2(alu_pkg::DATA_W)-1:0]  shamt;     // In range part of b

	// b taken as unsigned, a negative b counts as a huge shift
	assign shift_out = ($unsigned(issue.b) >= alu_pkg::SHAMT_LIMIT);
	assign shamt     = issue.b[$clog2(alu_pkg::DATA_W)-1:0];

	always_ff @(posedge clk) begin
		res.les <= alu_pkg::to_word(issue.a < issue.b);  // Both signed
		res.gre <= alu_pkg::to_word(issue.a > issue.b);
		res.equ <= alu_pkg::to_word(issue.a == issue.b);

		if (shift_out) begin
			res.shl <= '0;
			res.shr <= '0;
			res.srs <= issue.a >>> (alu_pkg::DATA_W - 1); // Sign fill
		end else begin
			res.shl <= issue.a << shamt;
			res.shr <= $unsigned(issue.a) >> shamt;        // Zero fill
			res.srs <= issue.a >>> shamt;                  // Arithmetic
		end
	end

	// Less and greater come from separate compares and must exclude each other
	assert property (@(posedge clk)
		!(res.les[0] === 1'b1 && res.gre[0] === 1'b1));

endmodule

//--- rtl/alu_result_sel.sv
/*
 * ALU result selector
 * Decodes the delayed opcode, picks the unit field and registers the output
 */

`timescale 1ns/1ps

module alu_result_sel (
	input  logic                    clk,
	input  logic                    reset,
	alu_issue_if.unit               issue,
	input  alu_pkg::arith_res_t     arith,
	input  alu_pkg::logic_res_t     logic_r,
	input  alu_pkg::cmp_shift_res_t cmp_shift,
	output logic                    out_valid,
	output logic                    out_illegal,
	output alu_pkg::alu_word_t      out_result
);

	logic               valid_d;  // Lines up with the unit structs
	alu_pkg::alu_op_e   op_d;
	logic               illegal;  // Code past the last legal op
	alu_pkg::alu_word_t sel;

	// ***********************************************************************
	// Stage 1, control alongside the unit registers
	// ***********************************************************************

	always_ff @(posedge clk) begin
		if (reset) valid_d <= 1'b0;
		else       valid_d <= issue.valid;
	end

	always_ff @(posedge clk) op_d <= issue.op; // Payload, no reset

	// ***********************************************************************
	// Decode and pick
	// ***********************************************************************

	assign illegal = (op_d > alu_pkg::OP_LAST);

	always_comb begin
		case (op_d)
			alu_pkg::NOP:   sel = arith.nop;
			alu_pkg::LOD:   sel = arith.lod;
			alu_pkg::ADD:   sel = arith.add;
			alu_pkg::MLT:   sel = arith.mlt;
			alu_pkg::SGN:   sel = arith.sgn;
			alu_pkg::NEG:   sel = arith.neg;
			alu_pkg::NEG_M: sel = arith.neg_m;
			alu_pkg::ABS:   sel = arith.abs;
			alu_pkg::ABS_M: sel = arith.abs_m;
			alu_pkg::PST:   sel = arith.pst;
			alu_pkg::PST_M: sel = arith.pst_m;
			alu_pkg::AND:   sel = logic_r.ann;
			alu_pkg::ORR:   sel = logic_r.orr;
			alu_pkg::XOR:   sel = logic_r.cor;
			alu_pkg::INV:   sel = logic_r.inv;
			alu_pkg::INV_M: sel = logic_r.inv_m;
			alu_pkg::LAN:   sel = logic_r.lan;
			alu_pkg::LOR:   sel = logic_r.lor;
			alu_pkg::LIN:   sel = logic_r.lin;
			alu_pkg::LIN_M: sel = logic_r.lin_m;
			alu_pkg::LES:   sel = cmp_shift.les;
			alu_pkg::GRE:   sel = cmp_shift.gre;
			alu_pkg::EQU:   sel = cmp_shift.equ;
			alu_pkg::SHL:   sel = cmp_shift.shl;
			alu_pkg::SHR:   sel = cmp_shift.shr;
			alu_pkg::SRS:   sel = cmp_shift.srs;
			default:        sel = '0;            // Illegal code reads as zero
		endcase
	end

	// Stage 2, output register
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid   <= 1'b0;
			out_illegal <= 1'b0;
		end else begin
			out_valid   <= valid_d;
			out_illegal <= valid_d && illegal; // Never without valid
		end
	end

	always_ff @(posedge clk) out_result <= sel;

	assert property (@(posedge clk) disable iff (reset) out_illegal |-> out_valid);

	assert property (@(posedge clk) reset |=> !out_valid);

	// Two cycle latency through unit and selector stages
	assert property (@(posedge clk) disable iff (reset)
		!$past(reset) && !$past(reset, 2) |-> out_valid == $past(issue.valid, 2));

endmodule

//--- rtl/alu_top.sv
/*
 * Pipelined integer ALU, top level
 * Two cycle fixed latency, one item per cycle, no back-pressure
 */

`timescale 1ns/1ps

module alu_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_valid,
	input  alu_pkg::alu_op_e   in_op,
	input  alu_pkg::alu_word_t in_a,      // Memory operand
	input  alu_pkg::alu_word_t in_b,      // Accumulator operand
	output logic               out_valid,
	output logic               out_illegal,
	output alu_pkg::alu_word_t out_result
);

	alu_pkg::arith_res_t     arith_res;
	alu_pkg::logic_res_t     logic_res;
	alu_pkg::cmp_shift_res_t cmp_shift_res;

	// ***********************************************************************
	// Issue bundle, plain ports straight in
	// ***********************************************************************

	alu_issue_if issue ();

	assign issue.valid = in_valid;
	assign issue.op    = in_op;
	assign issue.a     = in_a;
	assign issue.b     = in_b;

	// ***********************************************************************
	// Units, one register stage each
	// ***********************************************************************

	alu_arith alu_arith_i (
		.clk   (clk),
		.issue (issue),
		.res   (arith_res)
	);

	alu_logic alu_logic_i (
		.clk   (clk),
		.issue (issue),
		.res   (logic_res)
	);

	alu_cmp_shift alu_cmp_shift_i (
		.clk   (clk),
		.issue (issue),
		.res   (cmp_shift_res)
	);

	// Decode and output stage
	alu_result_sel alu_result_sel_i (
		.clk         (clk),
		.reset       (reset),
		.issue       (issue),
		.arith       (arith_res),
		.logic_r     (logic_res),
		.cmp_shift   (cmp_shift_res),
		.out_valid   (out_valid),
		.out_illegal (out_illegal),
		.out_result  (out_result)
	);

endmodule

//--- dv/alu_tb_ref.svh
/*
 * ALU testbench reference model
 * Expected results from the opcode rules, operand LFSR and compare tasks
 */

`ifndef ALU_TB_REF_SVH
`define ALU_TB_REF_SVH

// 1 or 0 as a full data word
function automatic alu_pkg::alu_word_t bool_word(input logic flag);
	return flag ? alu_pkg::alu_word_t'(1) : alu_pkg::alu_word_t'(0);
endfunction

// Expected result and illegal flag for one issued item
function automatic alu_pkg::alu_word_t ref_alu(
	input  logic [5:0]         op,
	input  alu_pkg::alu_word_t a,
	input  alu_pkg::alu_word_t b,
	output logic               illegal
);
	logic signed [63:0] prod;   // Full product with the low half kept
	logic        [31:0] amt;    // Shift amount as unsigned b
	logic               a_neg;
	logic               b_neg;
	alu_pkg::alu_word_t r;
	prod    = 64'(a) * 64'(b);
	amt     = b;
	a_neg   = a[alu_pkg::DATA_W-1];
	b_neg   = b[alu_pkg::DATA_W-1];
	illegal = (op > alu_pkg::OP_LAST);
	case (op)
		alu_pkg::NOP:   r = b;
		alu_pkg::LOD:   r = a;
		alu_pkg::ADD:   r = a + b;
		alu_pkg::MLT:   r = prod[31:0];
		alu_pkg::SGN:   r = (a_neg == b_neg) ? b : -b;  // b carries sign of a
		alu_pkg::NEG:   r = -b;
		alu_pkg::NEG_M: r = -a;
		alu_pkg::ABS:   r = b_neg ? -b : b;
		alu_pkg::ABS_M: r = a_neg ? -a : a;
		alu_pkg::PST:   r = b_neg ? '0 : b;
		alu_pkg::PST_M: r = a_neg ? '0 : a;
		alu_pkg::AND:   r = a & b;
		alu_pkg::ORR:   r = a | b;
		alu_pkg::XOR:   r = a ^ b;
		alu_pkg::INV:   r = ~b;
		alu_pkg::INV_M: r = ~a;
		alu_pkg::LAN:   r = bool_word((a != '0) && (b != '0));
		alu_pkg::LOR:   r = bool_word((a != '0) || (b != '0));
		alu_pkg::LIN:   r = bool_word(b == '0);
		alu_pkg::LIN_M: r = bool_word(a == '0);
		alu_pkg::LES:   r = bool_word(a < b);
		alu_pkg::GRE:   r = bool_word(a > b);
		alu_pkg::EQU:   r = bool_word(a == b);
		alu_pkg::SHL:   r = (amt >= alu_pkg::SHAMT_LIMIT) ? '0 : a << amt[4:0];
		alu_pkg::SHR:   r = (amt >= alu_pkg::SHAMT_LIMIT) ? '0 : $unsigned(a) >> amt[4:0];
		alu_pkg::SRS:   r = (amt >= alu_pkg::SHAMT_LIMIT) ? (a_neg ? -32'sd1 : 32'sd0)
		                                                  : a >>> amt[4:0];
		default:        r = '0;                         // Codes 26 to 63
	endcase
	return r;
endfunction

// One Galois LFSR step returning the bit shifted out
function automatic logic lfsr_bit();
	logic out;
	out        = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (out) lfsr_state = lfsr_state ^ 32'hA300_0000; // x^32+x^30+x^26+x^25+1
	return out;
endfunction

// n fresh bits with one step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
	return r;
endfunction

task automatic check_word(input string name, input alu_pkg::alu_word_t expected,
		input alu_pkg::alu_word_t actual);
	if (actual !== expected) begin
		mismatch_count++;
		$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected,
			actual);
	end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		mismatch_count++;
		$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
	end
endtask

`endif

//--- dv/alu_tb.sv
/*
 * ALU testbench
 * LFSR and edge stimulus, expected queue and a comparing process
 */

`timescale 1ns/1ps

module alu_tb;

	localparam int DRIVE_DELAY   = 2;   // ns after the rising edge
	localparam int DRAIN_TIMEOUT = 50;  // Cycles to wait for results

	typedef struct packed {
		alu_pkg::alu_word_t result;
		logic               illegal;
		logic [5:0]         op;
		int                 due;     // Cycle where the result should show
	} expect_t;

	logic               clk = 1'b0;
	logic               reset;
	logic               in_valid;
	alu_pkg::alu_op_e   in_op;
	alu_pkg::alu_word_t in_a;
	alu_pkg::alu_word_t in_b;
	logic               out_valid;
	logic               out_illegal;
	alu_pkg::alu_word_t out_result;

	int          cycle          = 0;
	int          mismatch_count = 0;
	int          protocol_count = 0;  // Missing, early, late or stray results
	logic [31:0] lfsr_state     = 32'd25375;
	expect_t     exp_q [$];

	// Operands that hit zero tests, sign rules and shift limits
	alu_pkg::alu_word_t edge_vals [8] = '{32'sd0, 32'sd1, 32'sd31, 32'sd32, 32'sd40,
		32'sh7fff_ffff, 32'sh8000_0000, -32'sd1};

	`include "alu_tb_ref.svh"

	always #20 clk = ~clk;  // 40 ns period

	always @(posedge clk) cycle <= cycle + 1;

	alu_top alu_top_i (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_op       (in_op),
		.in_a        (in_a),
		.in_b        (in_b),
		.out_valid   (out_valid),
		.out_illegal (out_illegal),
		.out_result  (out_result)
	);

	// ***********************************************************************
	// Stimulus helpers
	// ***********************************************************************

	function automatic logic [5:0] random_legal_op();
		logic [5:0] r;
		r = 6'(rand_bits(5));
		if (r > 6'd25) r = r - 6'd26;  // Fold 26..31 back in
		return r;
	endfunction

	// One item, expectation queued for the cycle it should come out
	task automatic drive_item(input logic [5:0] op, input alu_pkg::alu_word_t a,
			input alu_pkg::alu_word_t b);
		expect_t e;
		logic    ill;
		@(posedge clk);
		#DRIVE_DELAY;
		in_valid  = 1'b1;
		in_op     = alu_pkg::alu_op_e'(op);
		in_a      = a;
		in_b      = b;
		e.result  = ref_alu(op, a, b, ill);
		e.illegal = ill;
		e.op      = op;
		e.due     = cycle + 2;   // Two register stages
		exp_q.push_back(e);
	endtask

	// Bubble with junk operands
	task automatic drive_idle();
		@(posedge clk);
		#DRIVE_DELAY;
		in_valid = 1'b0;
		in_op    = alu_pkg::alu_op_e'(random_legal_op());
		in_a     = rand_bits(32);
		in_b     = rand_bits(32);
	endtask

	task automatic drive_random(input logic [5:0] op);
		alu_pkg::alu_word_t a;
		alu_pkg::alu_word_t b;
		a = rand_bits(32);
		b = rand_bits(1) ? rand_bits(6) : rand_bits(32);  // Small b half the time
		drive_item(op, a, b);
	endtask

	task automatic wait_drain(input int limit);
		int waited;
		drive_idle();
		waited = 0;
		while (exp_q.size() != 0 && waited < limit) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			protocol_count++;
			$display("Timeout at %0t ns: %0d results never came out", $time, exp_q.size());
			exp_q.delete();
		end
	endtask

	// ***********************************************************************
	// Comparing process, outputs are settled at the falling edge
	// ***********************************************************************

	always @(negedge clk) begin : compare_blk
		expect_t e;
		if (!reset) begin
			if (out_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					protocol_count++;
					$display("Unexpected out_valid at %0t ns with nothing in flight", $time);
				end else begin
					e = exp_q.pop_front();
					if (e.due != cycle) begin
						protocol_count++;
						$display("Result for op %0d came out in cycle %0d instead of %0d",
							e.op, cycle, e.due);
					end
					check_word("out_result", e.result, out_result);
					check_flag("out_illegal", e.illegal, out_illegal);
				end
			end else begin
				if (out_valid !== 1'b0) begin
					protocol_count++;
					$display("out_valid is unknown at %0t ns", $time);
				end
				check_flag("out_illegal", 1'b0, out_illegal);  // Forced low without valid
				if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
					protocol_count++;
					$display("Result for op %0d missing in cycle %0d", exp_q[0].op, cycle);
					void'(exp_q.pop_front());
				end
			end
		end
	end

	// ***********************************************************************
	// Test sequence
	// ***********************************************************************

	initial begin
		reset    = 1'b1;
		in_valid = 1'b0;
		in_op    = alu_pkg::NOP;
		in_a     = '0;
		in_b     = '0;
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		// Quiet after reset, then one lone item
		repeat (5) drive_idle();
		drive_item(6'(alu_pkg::ADD), 32'sd5, 32'sd7);
		wait_drain(DRAIN_TIMEOUT);

		// Every legal op on random operands
		for (int op = 0; op <= int'(alu_pkg::OP_LAST); op++) begin
			repeat (12) drive_random(6'(op));
		end
		wait_drain(DRAIN_TIMEOUT);

		// Edge operand grid
		for (int op = 0; op <= int'(alu_pkg::OP_LAST); op++) begin
			foreach (edge_vals[i]) begin
				foreach (edge_vals[j]) drive_item(6'(op), edge_vals[i], edge_vals[j]);
			end
		end
		wait_drain(DRAIN_TIMEOUT);

		// Back to back, mixed ops
		repeat (200) drive_random(random_legal_op());
		wait_drain(DRAIN_TIMEOUT);

		// Random bubbles in the stream
		repeat (150) begin
			if (rand_bits(2) == 0) drive_idle();
			else                   drive_random(random_legal_op());
		end
		wait_drain(DRAIN_TIMEOUT);

		// Illegal codes each chased by a legal item
		for (int op = int'(alu_pkg::OP_LAST) + 1; op < 64; op++) begin
			drive_random(6'(op));
			drive_random(random_legal_op());
		end
		wait_drain(DRAIN_TIMEOUT);

		repeat (3) drive_idle();
		$display("Checks done: %0d mismatches, %0d protocol errors",
			mismatch_count, protocol_count);
		if (mismatch_count == 0 && protocol_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- files.f
+incdir+dv
rtl/alu_pkg.sv
rtl/alu_issue_if.sv
rtl/alu_arith.sv
rtl/alu_logic.sv
rtl/alu_cmp_shift.sv
rtl/alu_result_sel.sv
rtl/alu_top.sv
dv/alu_tb.sv

//--- Makefile
# Verilator flow for the pipelined ALU

TOP  := alu_tb
SRCS := $(wildcard rtl/*.sv dv/*.sv dv/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module alu_top
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

obj_dir/V$(TOP): $(SRCS) files.f
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir

# Pass only if the log holds the pass line
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
